// File: src/spu_exec_params.svh
`ifndef SPU_EXEC_PARAMS_SVH
`define SPU_EXEC_PARAMS_SVH

// register file quadword width
`define SPU_QW_W 128

// opcode field as it arrives from the decoder
`define SPU_OPC_W 11

`define SPU_IMM_W 10 // i10 immediate field

// cycles from in_valid to out_valid
`define SPU_EXEC_LAT 2

`endif

// File: src/spu_isa_pkg.sv
`include "spu_exec_params.svh"

package spu_isa_pkg;

	localparam int RI10_OPC_W = 8; // ri10 opcodes only use the upper bits

	typedef enum logic [`SPU_OPC_W-1:0] {
		// rr forms, full 11 bit match
		OPC_AH    = 11'b00011001000, // add halfword
		OPC_A     = 11'b00011000000, // add word
		OPC_SFH   = 11'b00001001000, // subtract from halfword
		OPC_SF    = 11'b00001000000, // subtract from word
		OPC_AND   = 11'b00011000001,
		OPC_ANDC  = 11'b01011000001,
		OPC_OR    = 11'b00001000001,
		OPC_ORC   = 11'b01011001001,
		OPC_XOR   = 11'b01001000001,
		OPC_NAND  = 11'b00011001001,
		OPC_NOR   = 11'b00001001001,
		OPC_CEQH  = 11'b01111001000,
		OPC_CEQ   = 11'b01111000000,
		OPC_CGTH  = 11'b01001001000,
		OPC_CGT   = 11'b01001000000,
		OPC_CLGTH = 11'b01011001000,
		OPC_CLGT  = 11'b01011000000,
		OPC_CLZ   = 11'b01010100101, // word only
		// halfword pattern of clz, decoded so the lanes can reject it
		OPC_CLZH  = 11'b01010101101,
		// ri10 forms, left aligned with the low bits zero
		OPC_AHI    = 11'b00011101_000,
		OPC_AI     = 11'b00011100_000,
		OPC_SFHI   = 11'b00001101_000,
		OPC_SFI    = 11'b00001100_000,
		OPC_ANDHI  = 11'b00010101_000,
		OPC_ANDI   = 11'b00010100_000,
		OPC_ORHI   = 11'b00000101_000,
		OPC_ORI    = 11'b00000100_000,
		OPC_XORHI  = 11'b01000101_000,
		OPC_XORI   = 11'b01000100_000,
		OPC_CEQHI  = 11'b01111101_000,
		OPC_CEQI   = 11'b01111100_000,
		OPC_CGTHI  = 11'b01001101_000,
		OPC_CGTI   = 11'b01001100_000,
		OPC_CLGTHI = 11'b01011101_000,
		OPC_CLGTI  = 11'b01011100_000
	} spu_opcode_e;

	typedef enum logic {
		LANE_HW = 1'b0, // eight 16 bit lanes
		LANE_W  = 1'b1  // four 32 bit lanes
	} lane_size_e;

	typedef enum logic [3:0] {
		ADD, SFROM, AND, ANDC, OR, ORC, XOR, NAND, NOR,
		CEQ, CGT, CLGT, CLZ
	} alu_func_e;

endpackage

// File: src/spu_data_pkg.sv
`include "spu_exec_params.svh"

package spu_data_pkg;

	localparam int HW_W = 16;
	localparam int W_W  = 32;

	localparam int HW_LANES = `SPU_QW_W / HW_W; // 8
	localparam int W_LANES  = `SPU_QW_W / W_W;  // 4

	typedef logic [`SPU_QW_W-1:0] quadword_t;
	typedef logic [HW_W-1:0]      halfword_t;
	typedef logic [W_W-1:0]       word_t;

	// lane 0 is the least significant slice of the quadword
	typedef halfword_t [HW_LANES-1:0] hw_vec_t;
	typedef word_t     [W_LANES-1:0]  w_vec_t;

endpackage

// File: src/spu_op_if.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

interface spu_op_if
	import spu_isa_pkg::*, spu_data_pkg::*;
();
	logic       valid;   // one cycle per item
	alu_func_e  func;
	lane_size_e size;
	quadword_t  opa;     // ra
	quadword_t  opb;     // rb or replicated immediate
	logic       illegal;

	modport issue (
		output valid,
		output func,
		output size,
		output opa,
		output opb,
		output illegal
	);

	modport lanes (
		input valid,
		input func,
		input size,
		input opa,
		input opb,
		input illegal
	);

endinterface

// File: src/spu_res_if.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

interface spu_res_if
	import spu_isa_pkg::*, spu_data_pkg::*;
();
	logic       valid;
	lane_size_e size;    // picks which vector is the answer
	hw_vec_t    hw_res;
	w_vec_t     w_res;
	logic       illegal;

	modport lanes (
		output valid,
		output size,
		output hw_res,
		output w_res,
		output illegal
	);

	modport result (
		input valid,
		input size,
		input hw_res,
		input w_res,
		input illegal
	);

endinterface

// File: src/spu_issue_decode.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

module spu_issue_decode
	import spu_isa_pkg::*, spu_data_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  logic [`SPU_OPC_W-1:0] opcode,
	input  quadword_t             ra,
	input  quadword_t             rb,
	input  logic [`SPU_IMM_W-1:0] imm,
	spu_op_if.issue               op
);
	typedef struct packed {
		logic       known;
		logic       use_imm;
		lane_size_e size;
		alu_func_e  func;
	} dec_t;

	localparam int RI_PAD = `SPU_OPC_W - RI10_OPC_W;

	dec_t                  dec_rr;
	dec_t                  dec_ri;
	dec_t                  dec;
	logic [`SPU_OPC_W-1:0] opc_ri;
	halfword_t             imm_hw;
	word_t                 imm_w;
	quadword_t             opb_d;

	// low bits of an ri10 opcode are don't care
	assign opc_ri = {opcode[`SPU_OPC_W-1 -: RI10_OPC_W], {RI_PAD{1'b0}}};

	always_comb begin
		case (opcode)
			OPC_AH:    dec_rr = '{1'b1, 1'b0, LANE_HW, ADD};
			OPC_A:     dec_rr = '{1'b1, 1'b0, LANE_W, ADD};
			OPC_SFH:   dec_rr = '{1'b1, 1'b0, LANE_HW, SFROM};
			OPC_SF:    dec_rr = '{1'b1, 1'b0, LANE_W, SFROM};
			OPC_AND:   dec_rr = '{1'b1, 1'b0, LANE_W, AND};
			OPC_ANDC:  dec_rr = '{1'b1, 1'b0, LANE_W, ANDC};
			OPC_OR:    dec_rr = '{1'b1, 1'b0, LANE_W, OR};
			OPC_ORC:   dec_rr = '{1'b1, 1'b0, LANE_W, ORC};
			OPC_XOR:   dec_rr = '{1'b1, 1'b0, LANE_W, XOR};
			OPC_NAND:  dec_rr = '{1'b1, 1'b0, LANE_W, NAND};
			OPC_NOR:   dec_rr = '{1'b1, 1'b0, LANE_W, NOR};
			OPC_CEQH:  dec_rr = '{1'b1, 1'b0, LANE_HW, CEQ};
			OPC_CEQ:   dec_rr = '{1'b1, 1'b0, LANE_W, CEQ};
			OPC_CGTH:  dec_rr = '{1'b1, 1'b0, LANE_HW, CGT};
			OPC_CGT:   dec_rr = '{1'b1, 1'b0, LANE_W, CGT};
			OPC_CLGTH: dec_rr = '{1'b1, 1'b0, LANE_HW, CLGT};
			OPC_CLGT:  dec_rr = '{1'b1, 1'b0, LANE_W, CLGT};
			OPC_CLZ:   dec_rr = '{1'b1, 1'b0, LANE_W, CLZ};
			OPC_CLZH:  dec_rr = '{1'b1, 1'b0, LANE_HW, CLZ}; // rejected in the lanes
			default:   dec_rr = '{1'b0, 1'b0, LANE_W, ADD};
		endcase
	end

	always_comb begin
		case (opc_ri)
			OPC_AHI:    dec_ri = '{1'b1, 1'b1, LANE_HW, ADD};
			OPC_AI:     dec_ri = '{1'b1, 1'b1, LANE_W, ADD};
			OPC_SFHI:   dec_ri = '{1'b1, 1'b1, LANE_HW, SFROM};
			OPC_SFI:    dec_ri = '{1'b1, 1'b1, LANE_W, SFROM};
			OPC_ANDHI:  dec_ri = '{1'b1, 1'b1, LANE_HW, AND};
			OPC_ANDI:   dec_ri = '{1'b1, 1'b1, LANE_W, AND};
			OPC_ORHI:   dec_ri = '{1'b1, 1'b1, LANE_HW, OR};
			OPC_ORI:    dec_ri = '{1'b1, 1'b1, LANE_W, OR};
			OPC_XORHI:  dec_ri = '{1'b1, 1'b1, LANE_HW, XOR};
			OPC_XORI:   dec_ri = '{1'b1, 1'b1, LANE_W, XOR};
			OPC_CEQHI:  dec_ri = '{1'b1, 1'b1, LANE_HW, CEQ};
			OPC_CEQI:   dec_ri = '{1'b1, 1'b1, LANE_W, CEQ};
			OPC_CGTHI:  dec_ri = '{1'b1, 1'b1, LANE_HW, CGT};
			OPC_CGTI:   dec_ri = '{1'b1, 1'b1, LANE_W, CGT};
			OPC_CLGTHI: dec_ri = '{1'b1, 1'b1, LANE_HW, CLGT};
			OPC_CLGTI:  dec_ri = '{1'b1, 1'b1, LANE_W, CLGT};
			default:    dec_ri = '{1'b0, 1'b0, LANE_W, ADD};
		endcase
	end

	assign dec = dec_rr.known ? dec_rr : dec_ri; // rr patterns win

	// sign extend the i10 field to each lane width
	assign imm_hw = {{($bits(halfword_t) - `SPU_IMM_W){imm[`SPU_IMM_W-1]}}, imm};
	assign imm_w  = {{($bits(word_t) - `SPU_IMM_W){imm[`SPU_IMM_W-1]}}, imm};

	always_comb begin
		if (!dec.use_imm)
			opb_d = rb;
		else if (dec.size == LANE_HW)
			opb_d = {HW_LANES{imm_hw}}; // same immediate in every lane
		else
			opb_d = {W_LANES{imm_w}};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op.valid   <= 1'b0;
			op.illegal <= 1'b0;
		end else begin
			op.valid   <= in_valid;
			op.illegal <= in_valid & ~dec.known;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op.func <= dec.func;
			op.size <= dec.size;
			op.opa  <= ra;
			op.opb  <= opb_d;
		end
	end

	// a half driven opcode would decode to a random function
	a_opcode_known: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> !$isunknown(opcode))
		else $error("opcode has unknown bits while in_valid is high");

endmodule

// File: src/spu_lane_alu.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

module spu_lane_alu
	import spu_isa_pkg::*, spu_data_pkg::*;
#(
	parameter type lane_t = word_t
) (
	input  alu_func_e func,
	input  lane_t     a,
	input  lane_t     b,
	output lane_t     y
);
	localparam int LW = $bits(lane_t);

	lane_t clz;

	// only halfword and word lanes exist on this datapath
	if (!(LW == 16 || LW == 32)) begin : g_bad_width
		$fatal(1, "spu_lane_alu lane width %0d is not 16 or 32", LW);
	end

	// highest set bit decides, all zero gives the full width
	always_comb begin
		clz = lane_t'(LW);
		for (int i = 0; i < LW; i++) begin
			if (a[i])
				clz = lane_t'(LW - 1 - i);
		end
	end

	always_comb begin
		case (func)
			ADD:     y = a + b; // wraps per lane
			SFROM:   y = b - a; // subtract from, so b minus a
			AND:     y = a & b;
			ANDC:    y = a & ~b;
			OR:      y = a | b;
			ORC:     y = a | ~b;
			XOR:     y = a ^ b;
			NAND:    y = ~(a & b);
			NOR:     y = ~(a | b);
			CEQ:     y = (a == b) ? '1 : '0;
			CGT:     y = ($signed(a) > $signed(b)) ? '1 : '0;
			CLGT:    y = (a > b) ? '1 : '0; // unsigned
			CLZ:     y = clz;
			default: y = '0;
		endcase
	end

endmodule

// File: src/spu_simd_lanes.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

module spu_simd_lanes
	import spu_isa_pkg::*, spu_data_pkg::*;
(
	spu_op_if.lanes  op,
	spu_res_if.lanes res
);
	hw_vec_t   a_hw;
	hw_vec_t   b_hw;
	w_vec_t    a_w;
	w_vec_t    b_w;
	halfword_t hw_y [HW_LANES];
	word_t     w_y  [W_LANES];

	// same quadword seen as halfword and word lanes
	assign a_hw = op.opa;
	assign b_hw = op.opb;
	assign a_w  = op.opa;
	assign b_w  = op.opb;

	for (genvar i = 0; i < HW_LANES; i++) begin : g_hw
		spu_lane_alu #(
			.lane_t(halfword_t)
		) u_alu (
			.func(op.func),
			.a   (a_hw[i]),
			.b   (b_hw[i]),
			.y   (hw_y[i])
		);
	end

	for (genvar i = 0; i < W_LANES; i++) begin : g_w
		spu_lane_alu #(
			.lane_t(word_t)
		) u_alu (
			.func(op.func),
			.a   (a_w[i]),
			.b   (b_w[i]),
			.y   (w_y[i])
		);
	end

	always_comb begin
		for (int i = 0; i < HW_LANES; i++)
			res.hw_res[i] = hw_y[i];
		for (int i = 0; i < W_LANES; i++)
			res.w_res[i] = w_y[i];
	end

	assign res.valid = op.valid;
	assign res.size  = op.size;

	// clz has no halfword form
	assign res.illegal = op.illegal | (op.func == CLZ && op.size == LANE_HW);

endmodule

// File: src/spu_result_stage.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

module spu_result_stage
	import spu_isa_pkg::*, spu_data_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	spu_res_if.result res,
	output logic      out_valid,
	output quadword_t result,
	output logic      illegal_op
);
	quadword_t sel;

	always_comb begin
		if (res.illegal)
			sel = '0; // unknown op reads as zero
		else if (res.size == LANE_HW)
			sel = res.hw_res;
		else
			sel = res.w_res;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid  <= 1'b0;
			illegal_op <= 1'b0;
			result     <= '0;
		end else begin
			out_valid  <= res.valid;
			illegal_op <= res.valid & res.illegal;
			if (res.valid)
				result <= sel; // held until the next item
		end
	end

	// the lane view and the zero forcing both hang on these two bits
	a_res_ctrl_known: assert property (@(posedge clk) disable iff (!arst_n)
		res.valid |-> !$isunknown({res.size, res.illegal}))
		else $error("lane size or illegal flag unknown on a valid item");

endmodule

// File: src/spu_exec_top.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

module spu_exec_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  logic [`SPU_OPC_W-1:0] opcode,
	input  logic [`SPU_QW_W-1:0]  ra,
	input  logic [`SPU_QW_W-1:0]  rb,
	input  logic [`SPU_IMM_W-1:0] imm,
	output logic                  out_valid,
	output logic [`SPU_QW_W-1:0]  result,
	output logic                  illegal_op
);
	spu_op_if  op_if ();
	spu_res_if res_if ();

	spu_issue_decode u_issue (
		.clk     (clk),
		.arst_n  (arst_n),
		.in_valid(in_valid),
		.opcode  (opcode),
		.ra      (ra),
		.rb      (rb),
		.imm     (imm),
		.op      (op_if.issue)
	);

	spu_simd_lanes u_lanes (
		.op (op_if.lanes),
		.res(res_if.lanes)
	);

	spu_result_stage u_result (
		.clk       (clk),
		.arst_n    (arst_n),
		.res       (res_if.result),
		.out_valid (out_valid),
		.result    (result),
		.illegal_op(illegal_op)
	);

	// every issue comes back after a fixed number of cycles
	a_fixed_latency: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> ##(`SPU_EXEC_LAT) out_valid)
		else $error("out_valid missing %0d cycles after in_valid", `SPU_EXEC_LAT);

endmodule

// File: test/tb_spu_exec.sv
`timescale 1ns/1ps
`include "spu_exec_params.svh"

module tb_spu_exec
	import spu_isa_pkg::*, spu_data_pkg::*;
();
	typedef struct packed {
		logic      ill;
		quadword_t res;
	} exp_t;

	logic                  clk;
	logic                  arst_n;
	logic                  in_valid;
	logic [`SPU_OPC_W-1:0] opcode;
	quadword_t             ra;
	quadword_t             rb;
	logic [`SPU_IMM_W-1:0] imm;
	logic                  out_valid;
	quadword_t             result;
	logic                  illegal_op;

	exp_t        exp_q [$]; // one entry per issue, oldest first
	quadword_t   head_res;
	logic        head_ill;
	logic        head_live;
	logic        issued;
	logic [31:0] rng;
	string       cur_test;
	int          err_cnt;
	int          err_base;
	int          tests_run;
	int          tests_failed;

	spu_exec_top uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.opcode    (opcode),
		.ra        (ra),
		.rb        (rb),
		.imm       (imm),
		.out_valid (out_valid),
		.result    (result),
		.illegal_op(illegal_op)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function quadword_t rand_qw();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	// one lane, w bits wide, operands zero padded to 32
	function automatic logic [31:0] lane_result(input alu_func_e f, input int w,
		input logic [31:0] x, input logic [31:0] z);
		logic [31:0] mask;
		logic [31:0] xs;
		logic [31:0] zs;
		logic [31:0] r;
		int          n;
		mask = (w == 16) ? 32'h0000_ffff : 32'hffff_ffff;
		xs = (w == 16) ? {{16{x[15]}}, x[15:0]} : x; // signed views
		zs = (w == 16) ? {{16{z[15]}}, z[15:0]} : z;
		case (f)
			ADD:     r = x + z;
			SFROM:   r = z - x;
			AND:     r = x & z;
			ANDC:    r = x & ~z;
			OR:      r = x | z;
			ORC:     r = x | ~z;
			XOR:     r = x ^ z;
			NAND:    r = ~(x & z);
			NOR:     r = ~(x | z);
			CEQ:     r = (x == z) ? '1 : '0;
			CGT:     r = ($signed(xs) > $signed(zs)) ? '1 : '0;
			CLGT:    r = (x > z) ? '1 : '0;
			CLZ: begin
				n = 0;
				while (n < w && !x[w-1-n])
					n++;
				r = 32'(n);
			end
			default: r = '0;
		endcase
		return r & mask;
	endfunction

	function automatic quadword_t model(input alu_func_e f, input lane_size_e sz,
		input quadword_t a, input quadword_t b);
		quadword_t   y;
		logic [31:0] x;
		logic [31:0] z;
		logic [31:0] r;
		int          w;
		w = (sz == LANE_HW) ? 16 : 32;
		y = '0;
		for (int l = 0; l < `SPU_QW_W / w; l++) begin
			x = '0;
			z = '0;
			for (int k = 0; k < w; k++) begin
				x[k] = a[l*w + k];
				z[k] = b[l*w + k];
			end
			r = lane_result(f, w, x, z);
			for (int k = 0; k < w; k++)
				y[l*w + k] = r[k];
		end
		return y;
	endfunction

	task automatic issue_op(input logic [`SPU_OPC_W-1:0] opc, input alu_func_e f,
		input lane_size_e sz, input bit use_imm, input bit ill, input quadword_t a,
		input quadword_t b, input logic [`SPU_IMM_W-1:0] im);
		exp_t      e;
		quadword_t opb;
		int        w;
		w = (sz == LANE_HW) ? 16 : 32;
		opb = b;
		if (use_imm)
			for (int k = 0; k < `SPU_QW_W; k++)
				opb[k] = (k % w < `SPU_IMM_W) ? im[k % w] : im[`SPU_IMM_W-1]; // sign ext per lane
		e.ill = ill;
		e.res = ill ? '0 : model(f, sz, a, opb);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		opcode   = opc;
		ra       = a;
		rb       = b;
		imm      = im;
		issued   = 1'b1;
		exp_q.push_back(e);
	endtask

	// three issues: random, random, then one where compare equal hits
	task automatic run_ops(input logic [`SPU_OPC_W-1:0] opc, input alu_func_e f,
		input lane_size_e sz, input bit use_imm);
		quadword_t             a;
		quadword_t             b;
		logic [`SPU_IMM_W-1:0] im;
		logic [`SPU_OPC_W-1:0] o;
		int                    w;
		w = (sz == LANE_HW) ? 16 : 32;
		for (int n = 0; n < 3; n++) begin
			a = rand_qw();
			b = rand_qw();
			im = `SPU_IMM_W'(next_rand());
			o = opc;
			if (use_imm) begin
				o[2:0] = 3'(next_rand()); // low bits are don't care for ri10
				if (n == 2) begin
					im[`SPU_IMM_W-1] = 1'b1; // negative
					for (int k = 0; k < w; k++)
						a[k] = (k < `SPU_IMM_W) ? im[k] : im[`SPU_IMM_W-1];
				end
			end else if (n == 2) begin
				a = b;
			end
			issue_op(o, f, sz, use_imm, 1'b0, a, b, im);
		end
	endtask

	task automatic clz_cases();
		word_t w0;
		w0 = next_rand();
		issue_op(OPC_CLZ, CLZ, LANE_W, 1'b0, 1'b0,
			{w0 >> w0[4:0], 32'h1, 32'h8000_0000, 32'h0}, rand_qw(), '0);
		repeat (3) begin
			w0 = next_rand();
			issue_op(OPC_CLZ, CLZ, LANE_W, 1'b0, 1'b0, rand_qw() >> w0[6:0], rand_qw(), '0);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_base = err_cnt;
	endtask

	task automatic finish_test();
		int n;
		int errs;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %s still waits for %0d results", cur_test, exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
		@(posedge clk); // last check settles on this edge
		#1;
		errs = err_cnt - err_base;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("test %s %s (%0d errors)", cur_test, (errs == 0) ? "passed" : "failed", errs);
	endtask

	// pop mid cycle so the next edge samples a stable expected value
	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			head_live = (exp_q.size() != 0);
			if (head_live) begin
				{head_ill, head_res} = exp_q.pop_front();
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!issued |-> (!out_valid && !illegal_op && result == '0))
		else begin
			err_cnt++;
			$display("[ERROR] %s expected 0 0 %h actual %b %b %h", cur_test, '0,
				$sampled(out_valid), $sampled(illegal_op), $sampled(result));
		end

	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> ##(`SPU_EXEC_LAT) out_valid)
		else begin
			err_cnt++;
			$display("%s: out_valid did not come %0d cycles after an issue", cur_test,
				`SPU_EXEC_LAT);
		end

	a_expected_known: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> head_live)
		else begin
			err_cnt++;
			$display("%s: out_valid came with no issue waiting for it", cur_test);
		end

	a_result: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && head_live) |-> ({illegal_op, result} == {head_ill, head_res}))
		else begin
			err_cnt++;
			$display("[ERROR] %s expected %b %h actual %b %h", cur_test, head_ill, head_res,
				$sampled(illegal_op), $sampled(result));
		end

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		opcode       = '0;
		ra           = '0;
		rb           = '0;
		imm          = '0;
		issued       = 1'b0;
		head_live    = 1'b0;
		head_res     = '0;
		head_ill     = 1'b0;
		rng          = 32'h10ff;
		err_cnt      = 0;
		err_base     = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;

		begin_test("reset_idle");
		repeat (3) @(posedge clk);
		finish_test();

		begin_test("rr_forms");
		run_ops(OPC_AH, ADD, LANE_HW, 1'b0);
		run_ops(OPC_A, ADD, LANE_W, 1'b0);
		run_ops(OPC_SFH, SFROM, LANE_HW, 1'b0);
		run_ops(OPC_SF, SFROM, LANE_W, 1'b0);
		run_ops(OPC_AND, AND, LANE_W, 1'b0);
		run_ops(OPC_ANDC, ANDC, LANE_W, 1'b0);
		run_ops(OPC_OR, OR, LANE_W, 1'b0);
		run_ops(OPC_ORC, ORC, LANE_W, 1'b0);
		run_ops(OPC_XOR, XOR, LANE_W, 1'b0);
		run_ops(OPC_NAND, NAND, LANE_W, 1'b0);
		run_ops(OPC_NOR, NOR, LANE_W, 1'b0);
		run_ops(OPC_CEQH, CEQ, LANE_HW, 1'b0);
		run_ops(OPC_CEQ, CEQ, LANE_W, 1'b0);
		run_ops(OPC_CGTH, CGT, LANE_HW, 1'b0);
		run_ops(OPC_CGT, CGT, LANE_W, 1'b0);
		run_ops(OPC_CLGTH, CLGT, LANE_HW, 1'b0);
		run_ops(OPC_CLGT, CLGT, LANE_W, 1'b0);
		finish_test();

		begin_test("ri10_forms");
		run_ops(OPC_AHI, ADD, LANE_HW, 1'b1);
		run_ops(OPC_AI, ADD, LANE_W, 1'b1);
		run_ops(OPC_SFHI, SFROM, LANE_HW, 1'b1);
		run_ops(OPC_SFI, SFROM, LANE_W, 1'b1);
		run_ops(OPC_ANDHI, AND, LANE_HW, 1'b1);
		run_ops(OPC_ANDI, AND, LANE_W, 1'b1);
		run_ops(OPC_ORHI, OR, LANE_HW, 1'b1);
		run_ops(OPC_ORI, OR, LANE_W, 1'b1);
		run_ops(OPC_XORHI, XOR, LANE_HW, 1'b1);
		run_ops(OPC_XORI, XOR, LANE_W, 1'b1);
		run_ops(OPC_CEQHI, CEQ, LANE_HW, 1'b1);
		run_ops(OPC_CEQI, CEQ, LANE_W, 1'b1);
		run_ops(OPC_CGTHI, CGT, LANE_HW, 1'b1);
		run_ops(OPC_CGTI, CGT, LANE_W, 1'b1);
		run_ops(OPC_CLGTHI, CLGT, LANE_HW, 1'b1);
		run_ops(OPC_CLGTI, CLGT, LANE_W, 1'b1);
		finish_test();

		begin_test("clz_word");
		clz_cases();
		finish_test();

		begin_test("back_to_back");
		for (int i = 0; i < 8; i++) begin
			if (i == 5) begin
				@(posedge clk); // one idle slot in the stream
				#1;
				in_valid = 1'b0;
			end
			issue_op(i[0] ? OPC_SFH : OPC_A, i[0] ? SFROM : ADD, i[0] ? LANE_HW : LANE_W,
				1'b0, 1'b0, rand_qw(), rand_qw(), '0);
		end
		finish_test();

		begin_test("illegal_ops");
		issue_op({`SPU_OPC_W{1'b1}}, ADD, LANE_W, 1'b0, 1'b1, rand_qw(), rand_qw(), '0);
		issue_op(OPC_CLZH, CLZ, LANE_HW, 1'b0, 1'b1, rand_qw(), rand_qw(), '0);
		finish_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			err_cnt);
		if (tests_failed == 0 && err_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: spu_exec.f
+incdir+src
src/spu_isa_pkg.sv
src/spu_data_pkg.sv
src/spu_op_if.sv
src/spu_res_if.sv
src/spu_issue_decode.sv
src/spu_lane_alu.sv
src/spu_simd_lanes.sv
src/spu_result_stage.sv
src/spu_exec_top.sv
test/tb_spu_exec.sv

// File: Bender.yml
package:
  name: spu_exec

sources:
  - include_dirs:
      - src
    files:
      - src/spu_isa_pkg.sv
      - src/spu_data_pkg.sv
      - src/spu_op_if.sv
      - src/spu_res_if.sv
      - src/spu_issue_decode.sv
      - src/spu_lane_alu.sv
      - src/spu_simd_lanes.sv
      - src/spu_result_stage.sv
      - src/spu_exec_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_spu_exec.sv
